// File: source/sbc_usync_pkg.sv
//--------------------
// Crossing constants for the sideband configuration transfer
// Word width, reset value and the clk2 egress delay
//--------------------
`default_nettype none

package sbc_usync_pkg;

   // Configuration word width
   localparam int BUS_WIDTH = 16;

   // Reset value of the clk1 register, the hold register and q
   localparam logic [BUS_WIDTH-1:0] DATA_RST_VALUE = 16'h00a5;

   // Extra clk2 cycles between the resampled usync2 and capture
   // Must be at least 1 and no larger than the usync2 period
   localparam int EGRESS_DELAY = 2;

   // Egress counter must hold EGRESS_DELAY itself
   localparam int EGR_CNTR_WIDTH = $clog2(EGRESS_DELAY + 1);

endpackage : sbc_usync_pkg

`default_nettype wire

// File: source/sbc_cfg_pkg.sv
//--------------------
// Command definitions for the clk1 configuration register
//--------------------
`default_nettype none

package sbc_cfg_pkg;

   // Opcode field width
   localparam int OP_WIDTH = 3;

   // Commands applied to the configuration register
   // op_nop is the idle value of the op input
   typedef enum logic [OP_WIDTH-1:0] {
      op_nop    = 3'd0,
      op_write  = 3'd1,
      op_set    = 3'd2,
      op_clear  = 3'd3,
      op_toggle = 3'd4
   } sbc_cfg_op_e;

endpackage : sbc_cfg_pkg

`default_nettype wire

// File: source/sbc_cfg_launch_clk1.sv
//--------------------
// clk1 launch side of the configuration crossing
// Decodes commands into a read-modify-write of the config register,
// copies it into the hold register on usync1 only, and
// flags an update that has not been launched yet
//--------------------
`default_nettype none

module sbc_cfg_launch_clk1 (
   input  logic                                  clk1,
   input  logic                                  rst1_b,
   input  logic                                  usync1,
   input  sbc_cfg_pkg::sbc_cfg_op_e              op,
   input  logic [sbc_usync_pkg::BUS_WIDTH-1:0]   wdata,
   output logic [sbc_usync_pkg::BUS_WIDTH-1:0]   held_data,
   output logic                                  pending
);

   // Live configuration register and its next value
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] cfg_reg;
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] cfg_next;

   //--------------------
   // Command decode
   //--------------------

   // Read-modify-write of the register
   // Unknown encodings behave like op_nop
   always_comb begin
      case (op)
         sbc_cfg_pkg::op_write:  cfg_next = wdata;
         sbc_cfg_pkg::op_set:    cfg_next = cfg_reg | wdata;
         sbc_cfg_pkg::op_clear:  cfg_next = cfg_reg & ~wdata;
         sbc_cfg_pkg::op_toggle: cfg_next = cfg_reg ^ wdata;
         default:                cfg_next = cfg_reg;
      endcase
   end

   // Register update one clk1 cycle after the command
   always_ff @(posedge clk1 or negedge rst1_b) begin
      if (!rst1_b) begin
         cfg_reg <= sbc_usync_pkg::DATA_RST_VALUE;
      end else begin
         cfg_reg <= cfg_next;
      end
   end

   //--------------------
   // Launch on usync1
   //--------------------

   // Hold register changes only at a usync1 edge
   // It takes the register as it stands at the end of the usync1 cycle,
   // so a command sampled at that same edge waits for the next usync1
   // Stays stable through the whole clk2 capture window
   always_ff @(posedge clk1 or negedge rst1_b) begin
      if (!rst1_b) begin
         held_data <= sbc_usync_pkg::DATA_RST_VALUE;
      end else if (usync1) begin
         held_data <= cfg_reg;
      end
   end

   // Update waiting for launch
   // A new command wins over the launch in the same cycle
   always_ff @(posedge clk1 or negedge rst1_b) begin
      if (!rst1_b) begin
         pending <= 1'b0;
      end else if (op != sbc_cfg_pkg::op_nop) begin
         pending <= 1'b1;
      end else if (usync1) begin
         pending <= 1'b0;
      end
   end

endmodule : sbc_cfg_launch_clk1

`default_nettype wire

// File: source/sbc_usync_capture_clk2.sv
//--------------------
// clk2 capture side of the configuration crossing
// Synchronizes usync2 through a falling-edge and a rising-edge flop,
// waits a fixed egress delay, then captures the held clk1 word
// and registers it once more onto q
//--------------------
`default_nettype none

module sbc_usync_capture_clk2 (
   input  logic                                  clk2,
   input  logic                                  rst2_b,
   input  logic                                  usync2,
   input  logic [sbc_usync_pkg::BUS_WIDTH-1:0]   pre_sync_data,
   output logic [sbc_usync_pkg::BUS_WIDTH-1:0]   q
);

   // usync2 pipeline
   logic usync2_fall;
   logic usync2_rise;

   // Egress delay counter and capture strobe
   logic [sbc_usync_pkg::EGR_CNTR_WIDTH-1:0] egr_cntr;
   logic                                     capture_en;

   // Captured word before the output register
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] capture_data;

   //--------------------
   // usync2 synchronizer
   //--------------------

   // Falling edge stage, half a cycle after E0
   always_ff @(negedge clk2 or negedge rst2_b) begin
      if (!rst2_b) begin
         usync2_fall <= 1'b0;
      end else begin
         usync2_fall <= usync2;
      end
   end

   // Back onto the rising edge at E1
   always_ff @(posedge clk2 or negedge rst2_b) begin
      if (!rst2_b) begin
         usync2_rise <= 1'b0;
      end else begin
         usync2_rise <= usync2_fall;
      end
   end

   //--------------------
   // Egress delay
   //--------------------

   // Loads EGRESS_DELAY at E2, counts down to zero and parks there
   always_ff @(posedge clk2 or negedge rst2_b) begin
      if (!rst2_b) begin
         egr_cntr <= '0;
      end else if (usync2_rise) begin
         egr_cntr <= sbc_usync_pkg::EGR_CNTR_WIDTH'(sbc_usync_pkg::EGRESS_DELAY);
      end else if (egr_cntr != '0) begin
         egr_cntr <= egr_cntr - sbc_usync_pkg::EGR_CNTR_WIDTH'(1);
      end
   end

   // Last count enables capture at E0 + EGRESS_DELAY + 2
   assign capture_en = (egr_cntr == sbc_usync_pkg::EGR_CNTR_WIDTH'(1));

   //--------------------
   // Capture and output
   //--------------------

   always_ff @(posedge clk2 or negedge rst2_b) begin
      if (!rst2_b) begin
         capture_data <= sbc_usync_pkg::DATA_RST_VALUE;
      end else if (capture_en) begin
         capture_data <= pre_sync_data;
      end
   end

   // q follows one cycle later, E0 + EGRESS_DELAY + 3
   always_ff @(posedge clk2 or negedge rst2_b) begin
      if (!rst2_b) begin
         q <= sbc_usync_pkg::DATA_RST_VALUE;
      end else begin
         q <= capture_data;
      end
   end

endmodule : sbc_usync_capture_clk2

`default_nettype wire

// File: source/sbc_cfg_xfer.sv
//--------------------
// Sideband configuration transfer, top level
// clk1 command side launches on usync1,
// clk2 side captures after the usync2 egress delay
//--------------------
`default_nettype none

module sbc_cfg_xfer (
   // clk1 domain
   input  logic                                  clk1,
   input  logic                                  rst1_b,
   input  logic                                  usync1,
   input  sbc_cfg_pkg::sbc_cfg_op_e              op,
   input  logic [sbc_usync_pkg::BUS_WIDTH-1:0]   wdata,
   // clk2 domain
   input  logic                                  clk2,
   input  logic                                  rst2_b,
   input  logic                                  usync2,
   // Outputs
   output logic [sbc_usync_pkg::BUS_WIDTH-1:0]   q,
   output logic                                  pending
);

   // Hold register crossing into clk2, stable around the capture point
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] held_data;

   // Command decode, config register and launch
   sbc_cfg_launch_clk1 i_cfg_launch (
      .clk1      (clk1),
      .rst1_b    (rst1_b),
      .usync1    (usync1),
      .op        (op),
      .wdata     (wdata),
      .held_data (held_data),
      .pending   (pending)
   );

   // Synchronized usync2, egress delay and capture
   sbc_usync_capture_clk2 i_usync_capture (
      .clk2          (clk2),
      .rst2_b        (rst2_b),
      .usync2        (usync2),
      .pre_sync_data (held_data),
      .q             (q)
   );

endmodule : sbc_cfg_xfer

`default_nettype wire

// File: testbench/tb_sbc_cfg_xfer.sv
//--------------------
// Testbench for the sideband configuration crossing
// Reads commands from the pattern file, keeps a register model,
// checks pending, the fixed egress latency and q
//--------------------
`default_nettype none

module tb_sbc_cfg_xfer;

   timeunit 1ns;
   timeprecision 100ps;

   // DUT ports
   logic                                clk1 = 1'b0;
   logic                                clk2 = 1'b0;
   logic                                rst1_b;
   logic                                rst2_b;
   logic                                usync1 = 1'b0;
   logic                                usync2 = 1'b0;
   sbc_cfg_pkg::sbc_cfg_op_e            op;
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] wdata;
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] q;
   logic                                pending;

   // Position inside the 8 clk1 cycle usync period
   logic [2:0] usync_phase = 3'd0;

   // Pattern table
   string                               name_q[$];
   logic [3:0]                          mode_q[$];
   logic [sbc_cfg_pkg::OP_WIDTH-1:0]    op_q[$];
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] data_q[$];
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] exp_q[$];

   // Reference model state
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] model_value;
   logic [sbc_usync_pkg::BUS_WIDTH-1:0] prev_value;
   logic                                group_pending;
   logic [31:0]                         rnd_state;

   // Run length guard in clk2 cycles
   int cycle_cnt = 0;
   int cycle_limit;

   //--------------------
   // Clocks and usync pulses
   //--------------------

   // clk1 period 20 ns and clk2 period 40 ns with rising edges aligned
   always begin
      #10;
      clk1 = ~clk1;
      if (clk1) begin
         clk2 = ~clk2;
      end
   end

   // Both pulses rise at phase 6, which is an aligned edge
   // usync1 lasts one clk1 cycle, usync2 one clk2 cycle
   always @(posedge clk1) begin
      usync_phase <= usync_phase + 3'd1;
      usync1      <= (usync_phase == 3'd6);
      usync2      <= (usync_phase == 3'd6) || (usync_phase == 3'd7);
   end

   // Device under test
   sbc_cfg_xfer i_sbc_cfg_xfer (
      .clk1    (clk1),
      .rst1_b  (rst1_b),
      .usync1  (usync1),
      .op      (op),
      .wdata   (wdata),
      .clk2    (clk2),
      .rst2_b  (rst2_b),
      .usync2  (usync2),
      .q       (q),
      .pending (pending)
   );

   // Stops a run that never reaches its end
   always @(posedge clk2) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("TIMEOUT: the test did not finish within %0d clk2 cycles", cycle_limit);
         $display("Something failed");
         $fatal(1);
      end
   end

   //--------------------
   // Helpers
   //--------------------

   // Pseudo random source for the idle gaps
   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Register behavior per command
   function automatic logic [sbc_usync_pkg::BUS_WIDTH-1:0] model_apply(
      input logic [sbc_cfg_pkg::OP_WIDTH-1:0]  op_code,
      input logic [sbc_usync_pkg::BUS_WIDTH-1:0] cur,
      input logic [sbc_usync_pkg::BUS_WIDTH-1:0] data);
      logic [sbc_usync_pkg::BUS_WIDTH-1:0] result;
      case (op_code)
         sbc_cfg_pkg::op_write:  result = data;
         sbc_cfg_pkg::op_set:    result = cur | data;
         sbc_cfg_pkg::op_clear:  result = cur & ~data;
         sbc_cfg_pkg::op_toggle: result = cur ^ data;
         default:                result = cur;
      endcase
      return result;
   endfunction

   task automatic check_equal(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %0h actual %0h", test_name, expected, actual);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   // Pattern file into the tables
   task automatic load_patterns();
      int                                  fd;
      int                                  n;
      string                               line;
      string                               name;
      logic [3:0]                          mode;
      logic [sbc_cfg_pkg::OP_WIDTH-1:0]    op_code;
      logic [sbc_usync_pkg::BUS_WIDTH-1:0] data;
      logic [sbc_usync_pkg::BUS_WIDTH-1:0] expected;
      fd = $fopen("testbench/sbc_cfg_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the pattern file testbench/sbc_cfg_patterns.txt");
         $display("Something failed");
         $fatal(1);
      end
      while ($fgets(line, fd) != 0) begin
         // Lines starting with # describe the columns
         if (line.getc(0) == 8'h23) begin
            continue;
         end
         n = $sscanf(line, "%s %h %h %h %h", name, mode, op_code, data, expected);
         if (n == 5) begin
            name_q.push_back(name);
            mode_q.push_back(mode);
            op_q.push_back(op_code);
            data_q.push_back(data);
            exp_q.push_back(expected);
         end else if (n > 0) begin
            $display("Badly formed line in the pattern file: %s", line);
            $display("Something failed");
            $fatal(1);
         end
      end
      $fclose(fd);
      if (name_q.size() == 0) begin
         $display("The pattern file holds no commands");
         $display("Something failed");
         $fatal(1);
      end
   endtask

   // Ends on the launch edge, so a burst fits inside one usync period
   task automatic align_to_launch();
      @(negedge clk1);
      while (!usync1) @(negedge clk1);
      @(posedge clk1);
   endtask

   // Pending, launch and egress timing for the group just issued
   task automatic check_group(input string test_name);
      @(posedge clk1);
      op <= sbc_cfg_pkg::op_nop;
      @(negedge clk1);
      check_equal({test_name, " pending set"}, 32'(group_pending), 32'(pending));
      // usync1 high here means E0 was the clk2 edge just before
      while (!usync1) @(negedge clk1);
      @(posedge clk1);
      @(negedge clk1);
      check_equal({test_name, " pending clear"}, 32'd0, 32'(pending));
      // Capture at E0 + EGRESS_DELAY + 2 and q one edge later
      repeat (sbc_usync_pkg::EGRESS_DELAY + 2) @(posedge clk2);
      @(negedge clk2);
      check_equal({test_name, " q before egress"}, 32'(prev_value), 32'(q));
      @(posedge clk2);
      @(negedge clk2);
      check_equal({test_name, " q after egress"}, 32'(model_value), 32'(q));
      prev_value = model_value;
   endtask

   //--------------------
   // Main sequence
   //--------------------

   initial begin
      int   i;
      int   gap;
      logic chained;
      rst1_b        = 1'b0;
      rst2_b        = 1'b0;
      op            = sbc_cfg_pkg::op_nop;
      wdata         = '0;
      rnd_state     = 32'hb54e;
      model_value   = sbc_usync_pkg::DATA_RST_VALUE;
      prev_value    = sbc_usync_pkg::DATA_RST_VALUE;
      group_pending = 1'b0;
      chained       = 1'b0;

      load_patterns();
      cycle_limit = name_q.size() * 14 + 100;

      // Both resets low for 4 clk2 cycles
      repeat (4) @(posedge clk2);
      rst1_b <= 1'b1;
      rst2_b <= 1'b1;
      @(negedge clk2);
      check_equal("reset q", 32'(sbc_usync_pkg::DATA_RST_VALUE), 32'(q));
      // pending lives in clk1 and is read between clk1 edges
      @(negedge clk1);
      check_equal("reset pending", 32'd0, 32'(pending));

      for (i = 0; i < name_q.size(); i++) begin
         if (!chained) begin
            group_pending = 1'b0;
            if (mode_q[i] == 4'd1) begin
               align_to_launch();
            end else begin
               // Idle gap of 0 to 5 clk1 cycles
               rnd_state = xorshift32(rnd_state);
               gap = int'(rnd_state % 32'd6);
               repeat (gap) @(posedge clk1);
               @(posedge clk1);
            end
         end else begin
            @(posedge clk1);
         end
         op    <= sbc_cfg_pkg::sbc_cfg_op_e'(op_q[i]);
         wdata <= data_q[i];
         model_value = model_apply(op_q[i], model_value, data_q[i]);
         check_equal({name_q[i], " model vs file"}, 32'(exp_q[i]), 32'(model_value));
         if (op_q[i] != sbc_cfg_pkg::op_nop) begin
            group_pending = 1'b1;
         end
         chained = (mode_q[i] == 4'd1);
         if (!chained) begin
            check_group(name_q[i]);
         end
      end

      if (chained) begin
         $display("The pattern file ends inside a burst, its last group was never checked");
         $display("Something failed");
         $fatal(1);
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule : tb_sbc_cfg_xfer

`default_nettype wire

// File: testbench/sbc_cfg_patterns.txt
# name mode op wdata expected, hex except name; op 0 nop 1 write 2 set 3 clear 4 toggle
# mode 1 chains the next line into the same usync period, mode 0 ends a group and checks q
wr_a 0 1 1234 1234
set_a 0 2 00f0 12f4
clr_a 0 3 1004 02f0
tgl_a 0 4 ffff fd0f
nop_a 0 0 0000 fd0f
nop_b 0 0 ffff fd0f
wr_b 0 1 0000 0000
set_b 0 2 8001 8001
set_c 0 2 8001 8001
tgl_b 0 4 8001 0000
clr_b 0 3 ffff 0000
wr_c 0 1 a5a5 a5a5
tgl_c 0 4 5a5a ffff
clr_c 0 3 0f0f f0f0
bst1_wr 1 1 1111 1111
bst1_set 1 2 2222 3333
bst1_tgl 1 4 0303 3030
bst1_clr 0 3 3000 0030
wr_d 0 1 beef beef
tgl_d 0 4 beef 0000
set_d 0 2 0001 0001
bst2_wr 1 1 c3c3 c3c3
bst2_nop 1 0 ffff c3c3
bst2_set 0 2 0c0c cfcf
bst3_clr 1 3 000f cfc0
bst3_nop 0 0 0000 cfc0
wr_e 0 1 7fff 7fff
set_e 0 2 8000 ffff
clr_e 0 3 8000 7fff
tgl_e 0 4 0001 7ffe
bst4_wr 1 1 00a5 00a5
bst4_tgl 1 4 00ff 005a
bst4_tgl2 0 4 00ff 00a5
wr_f 0 1 4c2d 4c2d
clr_f 0 3 ffff 0000
tgl_f 0 4 5555 5555

// File: tb.f
source/sbc_usync_pkg.sv
source/sbc_cfg_pkg.sv
source/sbc_cfg_launch_clk1.sv
source/sbc_usync_capture_clk2.sv
source/sbc_cfg_xfer.sv
testbench/tb_sbc_cfg_xfer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sideband configuration crossing testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_sbc_cfg_xfer \
   -f tb.f

sim_output=$(./obj_dir/Vtb_sbc_cfg_xfer 2>&1) || true
echo "$sim_output"

if grep -qx "Everything OK" <<< "$sim_output"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
